//--- logic/arch_pkg.sv
package arch_pkg;

	// Sizes that describe the architectural machine as software sees it.
	// Nothing in here depends on how many physical registers exist.

	// Number of architectural integer registers.
	localparam int arch_regs = 32;

	// Width of an architectural register index.
	// Five bits cover registers 0 through 31.
	localparam int arch_idx_w = $clog2(arch_regs);

	// Largest number of instructions dispatched or retired in one cycle.
	// The core is two wide at both ends of the pipeline.
	localparam int group_w = 2;

	// Width of a per-cycle dispatch or retire count.
	// The legal counts are 0, 1 and 2; code 3 is never sent.
	localparam int count_w = $clog2(group_w + 1);

endpackage

//--- logic/free_list.sv
`timescale 1ns/1ps

// Circular queue of free physical tags.
// New tags leave at the tail, displaced tags come back in at the head.
// The entries between head and tail are tags that are in flight.
module free_list (
	input  logic                          clock,
	input  logic                          reset,
	input  logic [arch_pkg::count_w-1:0]  dispatch_num,
	input  logic [arch_pkg::count_w-1:0]  free_num,
	input  logic [rename_pkg::tag_w-1:0]  free_tag_0,
	input  logic [rename_pkg::tag_w-1:0]  free_tag_1,
	input  logic                          recover,
	output logic [rename_pkg::tag_w-1:0]  alloc_tag_0,
	output logic [rename_pkg::tag_w-1:0]  alloc_tag_1,
	output logic [rename_pkg::fl_ptr_w:0] free_count
);
	import arch_pkg::*;
	import rename_pkg::*;

	logic [tag_w-1:0]    entry [fl_depth];
	logic [fl_ptr_w-1:0] head;
	logic [fl_ptr_w-1:0] tail;
	logic [fl_ptr_w-1:0] head_plus_one;
	logic [fl_ptr_w-1:0] tail_plus_one;
	logic [fl_ptr_w:0]   occupancy;
	logic                free_one;
	logic                free_two;

	assign head_plus_one = head + 1'b1;
	assign tail_plus_one = tail + 1'b1;

	// The two oldest free tags are always offered.
	// The caller decides through dispatch_num how many it takes.
	assign alloc_tag_0 = entry[tail];
	assign alloc_tag_1 = entry[tail_plus_one];

	assign free_count = occupancy;

	assign free_one = (free_num != '0);
	assign free_two = (free_num == count_w'(2));

	// Head, tail and the number of allocatable tags.
	// A recover throws away every tag in flight, so the tail falls back to
	// the head and all 64 entries are free again.
	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			occupancy <= (fl_ptr_w + 1)'(fl_depth);
		end else if (recover) begin
			tail <= head;
			occupancy <= (fl_ptr_w + 1)'(fl_depth);
		end else begin
			// Both ends move by their counts in the same cycle.
			tail <= tail + fl_ptr_w'(dispatch_num);
			head <= head + fl_ptr_w'(free_num);
			occupancy <= occupancy - (fl_ptr_w + 1)'(dispatch_num)
				+ (fl_ptr_w + 1)'(free_num);
		end
	end

	// Tag storage.
	// A freed tag lands on an entry that was allocated earlier, so the
	// write never overlaps the two entries offered at the tail.
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < fl_depth; i++) begin
				entry[i] <= tag_w'(fl_first_tag + i);
			end
		end else if (!recover) begin
			// Instruction 0 is older, so its tag goes in first.
			if (free_one) begin
				entry[head] <= free_tag_0;
			end
			if (free_two) begin
				entry[head_plus_one] <= free_tag_1;
			end
		end
	end

endmodule

//--- logic/rename_map.sv
`timescale 1ns/1ps

// Speculative map table.
// It turns the architectural sources of a dispatch group into physical tags
// and records the newly allocated destination tags for later readers.
module rename_map (
	input  logic                          clock,
	input  logic                          reset,
	input  logic [arch_pkg::count_w-1:0]  dispatch_num,
	input  logic [arch_pkg::arch_idx_w-1:0] dispatch_dest_0,
	input  logic [arch_pkg::arch_idx_w-1:0] dispatch_dest_1,
	input  logic [arch_pkg::arch_idx_w-1:0] dispatch_src_a_0,
	input  logic [arch_pkg::arch_idx_w-1:0] dispatch_src_b_0,
	input  logic [arch_pkg::arch_idx_w-1:0] dispatch_src_a_1,
	input  logic [arch_pkg::arch_idx_w-1:0] dispatch_src_b_1,
	input  logic [rename_pkg::tag_w-1:0]  alloc_tag_0,
	input  logic [rename_pkg::tag_w-1:0]  alloc_tag_1,
	input  logic                          recover,
	input  logic [arch_pkg::arch_regs-1:0][rename_pkg::tag_w-1:0] arch_table,
	output logic [rename_pkg::tag_w-1:0]  src_tag_a_0,
	output logic [rename_pkg::tag_w-1:0]  src_tag_b_0,
	output logic [rename_pkg::tag_w-1:0]  src_tag_a_1,
	output logic [rename_pkg::tag_w-1:0]  src_tag_b_1
);
	import arch_pkg::*;
	import rename_pkg::*;

	logic [arch_regs-1:0][tag_w-1:0] spec_table;
	logic dispatch_one;
	logic dispatch_two;
	logic bypass_a_1;
	logic bypass_b_1;

	assign dispatch_one = (dispatch_num != '0);
	assign dispatch_two = (dispatch_num == count_w'(2));

	// Instruction 0 is the oldest in the group.
	// Its sources only ever see state written in earlier cycles.
	assign src_tag_a_0 = spec_table[dispatch_src_a_0];
	assign src_tag_b_0 = spec_table[dispatch_src_b_0];

	// Instruction 1 may read what instruction 0 writes in the same group.
	// The table has not been written yet, so the new tag is forwarded.
	assign bypass_a_1 = dispatch_two && (dispatch_src_a_1 == dispatch_dest_0);
	assign bypass_b_1 = dispatch_two && (dispatch_src_b_1 == dispatch_dest_0);

	always_comb begin
		if (bypass_a_1) begin
			src_tag_a_1 = alloc_tag_0;
		end else begin
			src_tag_a_1 = spec_table[dispatch_src_a_1];
		end
	end

	always_comb begin
		if (bypass_b_1) begin
			src_tag_b_1 = alloc_tag_0;
		end else begin
			src_tag_b_1 = spec_table[dispatch_src_b_1];
		end
	end

	// Table update.
	// On a flush the committed mapping replaces everything speculative,
	// and any dispatch in that cycle is dropped.
	always_ff @(posedge clock) begin
		if (reset) begin
			// Register i starts out in physical register i.
			for (int i = 0; i < arch_regs; i++) begin
				spec_table[i] <= tag_w'(i);
			end
		end else if (recover) begin
			spec_table <= arch_table;
		end else begin
			if (dispatch_one) begin
				spec_table[dispatch_dest_0] <= alloc_tag_0;
			end
			// The later write wins when both name the same register.
			if (dispatch_two) begin
				spec_table[dispatch_dest_1] <= alloc_tag_1;
			end
		end
	end

endmodule

//--- logic/rename_pkg.sv
package rename_pkg;

	// Sizes of the physical register file and of the free list that
	// hands out its tags.

	// Number of physical registers.
	// This is the 32 architectural registers plus 64 rename registers.
	localparam int phys_regs = 96;

	// Width of a physical tag.
	localparam int tag_w = $clog2(phys_regs);

	// Number of entries in the free list.
	// Every physical register that is not architecturally mapped after
	// reset starts out in the free list.
	localparam int fl_depth = 64;

	// Width of a free-list head or tail pointer.
	// The pointers wrap naturally at the depth.
	localparam int fl_ptr_w = $clog2(fl_depth);

	// First tag placed in the free list at reset.
	// Entry i holds tag fl_first_tag + i, and the tags below it belong to
	// the identity mapping of the architectural registers.
	localparam int fl_first_tag = phys_regs - fl_depth;

endpackage

//--- logic/rename_top.sv
`timescale 1ns/1ps

// Rename subsystem of the two-wide core.
// Dispatch is renamed by the speculative map, retire goes through the
// architectural map, and the free list sits between them.
module rename_top (
	input  logic                            clock,
	input  logic                            reset,
	input  logic [arch_pkg::count_w-1:0]    dispatch_num,
	input  logic [arch_pkg::arch_idx_w-1:0] dispatch_dest_0,
	input  logic [arch_pkg::arch_idx_w-1:0] dispatch_dest_1,
	input  logic [arch_pkg::arch_idx_w-1:0] dispatch_src_a_0,
	input  logic [arch_pkg::arch_idx_w-1:0] dispatch_src_b_0,
	input  logic [arch_pkg::arch_idx_w-1:0] dispatch_src_a_1,
	input  logic [arch_pkg::arch_idx_w-1:0] dispatch_src_b_1,
	input  logic [arch_pkg::count_w-1:0]    retire_num,
	input  logic [arch_pkg::arch_idx_w-1:0] retire_dest_0,
	input  logic [arch_pkg::arch_idx_w-1:0] retire_dest_1,
	input  logic [rename_pkg::tag_w-1:0]    retire_tag_0,
	input  logic [rename_pkg::tag_w-1:0]    retire_tag_1,
	input  logic                            recover,
	output logic [rename_pkg::tag_w-1:0]    new_tag_0,
	output logic [rename_pkg::tag_w-1:0]    new_tag_1,
	output logic [rename_pkg::tag_w-1:0]    src_tag_a_0,
	output logic [rename_pkg::tag_w-1:0]    src_tag_b_0,
	output logic [rename_pkg::tag_w-1:0]    src_tag_a_1,
	output logic [rename_pkg::tag_w-1:0]    src_tag_b_1,
	output logic [rename_pkg::tag_w-1:0]    old_tag_0,
	output logic [rename_pkg::tag_w-1:0]    old_tag_1,
	output logic [rename_pkg::fl_ptr_w:0]   free_count
);
	import arch_pkg::*;
	import rename_pkg::*;

	logic [tag_w-1:0]                alloc_tag_0;
	logic [tag_w-1:0]                alloc_tag_1;
	logic [count_w-1:0]              free_num;
	logic [tag_w-1:0]                free_tag_0;
	logic [tag_w-1:0]                free_tag_1;
	logic [arch_regs-1:0][tag_w-1:0] arch_table;

	// The tags handed to the map are also the new destination tags.
	assign new_tag_0 = alloc_tag_0;
	assign new_tag_1 = alloc_tag_1;

	// The displaced tags are reported as they go back to the free list.
	assign old_tag_0 = free_tag_0;
	assign old_tag_1 = free_tag_1;

	rename_map u_rename_map (
		.clock            (clock),
		.reset            (reset),
		.dispatch_num     (dispatch_num),
		.dispatch_dest_0  (dispatch_dest_0),
		.dispatch_dest_1  (dispatch_dest_1),
		.dispatch_src_a_0 (dispatch_src_a_0),
		.dispatch_src_b_0 (dispatch_src_b_0),
		.dispatch_src_a_1 (dispatch_src_a_1),
		.dispatch_src_b_1 (dispatch_src_b_1),
		.alloc_tag_0      (alloc_tag_0),
		.alloc_tag_1      (alloc_tag_1),
		.recover          (recover),
		.arch_table       (arch_table),
		.src_tag_a_0      (src_tag_a_0),
		.src_tag_b_0      (src_tag_b_0),
		.src_tag_a_1      (src_tag_a_1),
		.src_tag_b_1      (src_tag_b_1)
	);

	free_list u_free_list (
		.clock        (clock),
		.reset        (reset),
		.dispatch_num (dispatch_num),
		.free_num     (free_num),
		.free_tag_0   (free_tag_0),
		.free_tag_1   (free_tag_1),
		.recover      (recover),
		.alloc_tag_0  (alloc_tag_0),
		.alloc_tag_1  (alloc_tag_1),
		.free_count   (free_count)
	);

	retire_map u_retire_map (
		.clock         (clock),
		.reset         (reset),
		.retire_num    (retire_num),
		.retire_dest_0 (retire_dest_0),
		.retire_dest_1 (retire_dest_1),
		.retire_tag_0  (retire_tag_0),
		.retire_tag_1  (retire_tag_1),
		.recover       (recover),
		.free_num      (free_num),
		.free_tag_0    (free_tag_0),
		.free_tag_1    (free_tag_1),
		.arch_table    (arch_table)
	);

endmodule

//--- logic/retire_map.sv
`timescale 1ns/1ps

// Architectural map table.
// It holds the committed mapping and, for every retiring instruction, finds
// the physical tag the instruction displaced so it can be freed.
module retire_map (
	input  logic                            clock,
	input  logic                            reset,
	input  logic [arch_pkg::count_w-1:0]    retire_num,
	input  logic [arch_pkg::arch_idx_w-1:0] retire_dest_0,
	input  logic [arch_pkg::arch_idx_w-1:0] retire_dest_1,
	input  logic [rename_pkg::tag_w-1:0]    retire_tag_0,
	input  logic [rename_pkg::tag_w-1:0]    retire_tag_1,
	input  logic                            recover,
	output logic [arch_pkg::count_w-1:0]    free_num,
	output logic [rename_pkg::tag_w-1:0]    free_tag_0,
	output logic [rename_pkg::tag_w-1:0]    free_tag_1,
	output logic [arch_pkg::arch_regs-1:0][rename_pkg::tag_w-1:0] arch_table
);
	import arch_pkg::*;
	import rename_pkg::*;

	logic [arch_regs-1:0][tag_w-1:0] commit_table;
	logic retire_one;
	logic retire_two;
	logic same_dest;

	assign retire_one = (retire_num != '0);
	assign retire_two = (retire_num == count_w'(2));

	// Every retired instruction frees exactly one tag.
	assign free_num = retire_num;

	// The older instruction displaces whatever is committed now.
	assign free_tag_0 = commit_table[retire_dest_0];

	// When both retire to one register, the younger one displaces the tag
	// that the older one is committing in this very cycle.
	assign same_dest = retire_two && (retire_dest_1 == retire_dest_0);
	assign free_tag_1 = same_dest ? retire_tag_0 : commit_table[retire_dest_1];

	// The speculative map copies this table on a flush.
	assign arch_table = commit_table;

	// Commit the retired destinations.
	// A flush cancels any retire in the same cycle.
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < arch_regs; i++) begin
				commit_table[i] <= tag_w'(i);
			end
		end else if (!recover) begin
			if (retire_one) begin
				commit_table[retire_dest_0] <= retire_tag_0;
			end
			// Written second, so the younger instruction wins a shared
			// destination.
			if (retire_two) begin
				commit_table[retire_dest_1] <= retire_tag_1;
			end
		end
	end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir run.log
verilator --binary --timing -Wno-fatal --top-module rename_tb -f src.f -o rename_sim \
	&& ./obj_dir/rename_sim > run.log 2>&1 \
	|| { cat run.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat run.log
grep -qF '** FAIL **' run.log && exit 1
exit 0

//--- src.f
logic/arch_pkg.sv
logic/rename_pkg.sv
logic/free_list.sv
logic/rename_map.sv
logic/retire_map.sv
logic/rename_top.sv
tests/rename_props.sv
tests/rename_tb.sv

//--- tests/rename_props.sv
`timescale 1ns/1ps

// Checks on the free list that hold in every cycle out of reset.
// It is bound into free_list, so the names below are the free list's own.
module rename_props (
	input logic                          clock,
	input logic                          reset,
	input logic [arch_pkg::count_w-1:0]  dispatch_num,
	input logic [arch_pkg::count_w-1:0]  free_num,
	input logic [rename_pkg::fl_ptr_w:0] free_count
);
	import arch_pkg::*;
	import rename_pkg::*;

	// A count of 3 does not exist on a two-wide machine.
	dispatch_count_legal: assert property (@(posedge clock) disable iff (reset)
		dispatch_num != count_w'(3))
		else $error("dispatch count of 3 seen by the free list");

	free_count_legal: assert property (@(posedge clock) disable iff (reset)
		free_num != count_w'(3))
		else $error("free count of 3 seen by the free list");

	// The caller may never take more tags than are offered.
	dispatch_within_occupancy: assert property (@(posedge clock) disable iff (reset)
		(fl_ptr_w + 1)'(dispatch_num) <= free_count)
		else $error("dispatch asked for more tags than the free list holds");

	// The queue never holds more tags than it has entries.
	occupancy_bounded: assert property (@(posedge clock) disable iff (reset)
		free_count <= (fl_ptr_w + 1)'(fl_depth))
		else $error("free list occupancy above its depth");

endmodule

//--- tests/rename_tb.sv
`timescale 1ns/1ps

// Testbench for the rename subsystem.
// A reference model of both maps, the free queue and the in-flight list
// predicts every output; each line of the data file is one test.
module rename_tb;
	import arch_pkg::*;
	import rename_pkg::*;

	logic clock;
	logic reset;
	logic recover;
	logic [count_w-1:0] dispatch_num;
	logic [count_w-1:0] retire_num;
	logic [arch_idx_w-1:0] dispatch_dest_0, dispatch_dest_1, retire_dest_0, retire_dest_1;
	logic [arch_idx_w-1:0] dispatch_src_a_0, dispatch_src_b_0;
	logic [arch_idx_w-1:0] dispatch_src_a_1, dispatch_src_b_1;
	logic [tag_w-1:0] retire_tag_0, retire_tag_1, new_tag_0, new_tag_1, old_tag_0, old_tag_1;
	logic [tag_w-1:0] src_tag_a_0, src_tag_b_0, src_tag_a_1, src_tag_b_1;
	logic [fl_ptr_w:0] free_count;

	// Reference state. Entries, pointers and maps follow the rename rules.
	int spec[arch_regs];
	int arch[arch_regs];
	int ent[fl_depth];
	int head;
	int tail;
	int occ;
	int fly_dest[$];
	int fly_tag[$];
	int seed = 27;
	int test_errors;
	int seen_new0, seen_new1, seen_a0, seen_a1, seen_old0, seen_old1, seen_count;
	logic [8*24-1:0] name_buf;

	rename_top DUT (.*);

	bind free_list rename_props props (.clock(clock), .reset(reset),
		.dispatch_num(dispatch_num), .free_num(free_num), .free_count(free_count));

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// Runaway guard on the whole run.
	initial begin
		for (int c = 0; c < 20000; c++) @(posedge clock);
		$display("The run did not finish within 20000 cycles and was stopped.");
		$display("** FAIL **");
		$finish;
	end

	task automatic check_value(input string what, input int expected, input int actual);
		if (expected != actual) begin
			$display("FAIL %0s %0s expected %0d actual %0d", name_buf, what, expected, actual);
			test_errors++;
		end
	endtask

	// One cycle: drive at the rising edge, check at the falling edge, then
	// advance the model to the state the next rising edge produces.
	task automatic step(input int nd, input int d0, input int d1, input int sa0,
			input int sb0, input int sa1, input int sb1, input int nr, input bit rec);
		int rd0, rd1, rt0, rt1, e_new0, e_new1, e_a1, e_b1, e_old0, e_old1;
		rd0 = 0;
		rd1 = 0;
		rt0 = 0;
		rt1 = 0;
		if (nd > occ) nd = occ;
		if (nr > fly_dest.size()) nr = fly_dest.size();
		// The oldest in-flight instructions retire first.
		if (nr >= 1) begin
			rd0 = fly_dest[0];
			rt0 = fly_tag[0];
		end
		if (nr == 2) begin
			rd1 = fly_dest[1];
			rt1 = fly_tag[1];
		end
		@(posedge clock);
		dispatch_num <= count_w'(nd);
		dispatch_dest_0 <= arch_idx_w'(d0);
		dispatch_dest_1 <= arch_idx_w'(d1);
		dispatch_src_a_0 <= arch_idx_w'(sa0);
		dispatch_src_b_0 <= arch_idx_w'(sb0);
		dispatch_src_a_1 <= arch_idx_w'(sa1);
		dispatch_src_b_1 <= arch_idx_w'(sb1);
		retire_num <= count_w'(nr);
		retire_dest_0 <= arch_idx_w'(rd0);
		retire_dest_1 <= arch_idx_w'(rd1);
		retire_tag_0 <= tag_w'(rt0);
		retire_tag_1 <= tag_w'(rt1);
		recover <= rec;
		@(negedge clock);
		e_new0 = ent[tail];
		e_new1 = ent[(tail + 1) % fl_depth];
		// Instruction 1 sees instruction 0's new tag inside one group.
		e_a1 = (nd == 2 && sa1 == d0) ? e_new0 : spec[sa1];
		e_b1 = (nd == 2 && sb1 == d0) ? e_new0 : spec[sb1];
		e_old0 = arch[rd0];
		e_old1 = (nr == 2 && rd1 == rd0) ? rt0 : arch[rd1];
		check_value("new_tag_0", e_new0, int'(new_tag_0));
		check_value("new_tag_1", e_new1, int'(new_tag_1));
		check_value("src_tag_a_0", spec[sa0], int'(src_tag_a_0));
		check_value("src_tag_b_0", spec[sb0], int'(src_tag_b_0));
		check_value("src_tag_a_1", e_a1, int'(src_tag_a_1));
		check_value("src_tag_b_1", e_b1, int'(src_tag_b_1));
		check_value("free_count", occ, int'(free_count));
		if (!rec && nr >= 1) check_value("old_tag_0", e_old0, int'(old_tag_0));
		if (!rec && nr == 2) check_value("old_tag_1", e_old1, int'(old_tag_1));
		seen_new0 = int'(new_tag_0);
		seen_new1 = int'(new_tag_1);
		seen_a0 = int'(src_tag_a_0);
		seen_a1 = int'(src_tag_a_1);
		seen_old0 = int'(old_tag_0);
		seen_old1 = int'(old_tag_1);
		seen_count = int'(free_count);
		if (rec) begin
			// A flush drops everything in flight and frees all 64 entries.
			spec = arch;
			tail = head;
			occ = fl_depth;
			fly_dest.delete();
			fly_tag.delete();
		end else begin
			if (nr >= 1) begin
				arch[rd0] = rt0;
				ent[head] = e_old0;
			end
			if (nr == 2) begin
				arch[rd1] = rt1;
				ent[(head + 1) % fl_depth] = e_old1;
			end
			repeat (nr) begin
				void'(fly_dest.pop_front());
				void'(fly_tag.pop_front());
			end
			if (nd >= 1) begin
				spec[d0] = e_new0;
				fly_dest.push_back(d0);
				fly_tag.push_back(e_new0);
			end
			if (nd == 2) begin
				spec[d1] = e_new1;
				fly_dest.push_back(d1);
				fly_tag.push_back(e_new1);
			end
			head = (head + nr) % fl_depth;
			tail = (tail + nd) % fl_depth;
			occ = occ - nd + nr;
		end
	endtask

	initial begin
		int fd, code, n, d0, d1, sa0, sb0, sa1, sb1, ex, ey, ec, fault, tests, failed, w;
		logic [8*200-1:0] line;
		logic [8*16-1:0] op_buf;
		fault = 0;
		tests = 0;
		failed = 0;
		reset = 1'b1;
		recover = 1'b0;
		dispatch_num = '0;
		retire_num = '0;
		dispatch_dest_0 = '0;
		dispatch_dest_1 = '0;
		dispatch_src_a_0 = '0;
		dispatch_src_b_0 = '0;
		dispatch_src_a_1 = '0;
		dispatch_src_b_1 = '0;
		retire_dest_0 = '0;
		retire_dest_1 = '0;
		retire_tag_0 = '0;
		retire_tag_1 = '0;
		for (int i = 0; i < arch_regs; i++) begin
			spec[i] = i;
			arch[i] = i;
		end
		for (int i = 0; i < fl_depth; i++) ent[i] = fl_first_tag + i;
		head = 0;
		tail = 0;
		occ = fl_depth;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		w = 0;
		while (free_count != (fl_ptr_w + 1)'(fl_depth) && w < 10) begin
			@(negedge clock);
			w++;
		end
		if (w >= 10) begin
			$display("The free list never reported 64 free tags after reset.");
			fault = 1;
		end
		fd = $fopen("tests/rename_testdata.txt", "r");
		if (fd == 0) begin
			$display("The data file tests/rename_testdata.txt could not be opened.");
			fault = 1;
		end else begin
			while (!$feof(fd)) begin
				line = '0;
				code = $fgets(line, fd);
				code = $sscanf(line, "%s %s %d %d %d %d %d %d %d %d %d %d", name_buf, op_buf,
					n, d0, d1, sa0, sb0, sa1, sb1, ex, ey, ec);
				// Comment lines and blank lines do not carry all twelve fields.
				if (code == 12) begin
					test_errors = 0;
					if (op_buf == "dispatch") begin
						step(n, d0, d1, sa0, sb0, sa1, sb1, 0, 1'b0);
						if (ex >= 0) check_value("file new_tag_0", ex, seen_new0);
						if (ey >= 0) check_value("file new_tag_1", ey, seen_new1);
					end else if (op_buf == "look") begin
						step(0, 0, 0, sa0, sb0, sa1, sb1, 0, 1'b0);
						if (ex >= 0) check_value("file src_tag_a_0", ex, seen_a0);
						if (ey >= 0) check_value("file src_tag_a_1", ey, seen_a1);
					end else if (op_buf == "retire") begin
						step(0, 0, 0, sa0, sb0, sa1, sb1, n, 1'b0);
						if (ex >= 0) check_value("file old_tag_0", ex, seen_old0);
						if (ey >= 0) check_value("file old_tag_1", ey, seen_old1);
					end else if (op_buf == "recover") begin
						step(0, 0, 0, sa0, sb0, sa1, sb1, 0, 1'b1);
					end else if (op_buf == "random") begin
						for (int i = 0; i < n; i++) begin
							step({$random(seed)} % 3, {$random(seed)} % 32, {$random(seed)} % 32,
								{$random(seed)} % 32, {$random(seed)} % 32,
								{$random(seed)} % 32, {$random(seed)} % 32,
								{$random(seed)} % 3, 1'b0);
						end
					end else begin
						$display("Test %0s names an unknown operation %0s.", name_buf, op_buf);
						test_errors++;
					end
					if (ec >= 0) check_value("file free_count", ec, seen_count);
					tests++;
					if (test_errors == 0) begin
						$display("test %0s passed", name_buf);
					end else begin
						$display("test %0s failed with %0d wrong values", name_buf, test_errors);
						failed++;
					end
				end
			end
			$fclose(fd);
		end
		$display("%0d tests run, %0d passed, %0d failed", tests, tests - failed, failed);
		if (failed == 0 && fault == 0 && tests > 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- tests/rename_testdata.txt
# name op num dest0 dest1 src_a0 src_b0 src_a1 src_b1 exp_x exp_y exp_count
# exp_x and exp_y are new tags, source a tags or old tags by op; -1 skips a check
reset_idle look 0 0 0 1 2 3 4 1 3 64
dispatch_pair dispatch 2 5 6 1 2 3 4 32 33 64
read_pair look 0 0 0 5 6 6 5 32 33 62
bypass_group dispatch 2 7 8 1 2 7 3 34 35 62
same_dest dispatch 2 9 9 0 0 0 0 36 37 60
read_same look 0 0 0 9 9 9 9 37 37 58
retire_pair retire 2 0 0 0 0 0 0 5 6 58
retire_next retire 2 0 0 0 0 0 0 7 8 60
retire_shared retire 2 0 0 0 0 0 0 9 36 62
dispatch_more dispatch 2 10 11 5 9 0 0 38 39 64
flush recover 0 0 0 0 0 0 0 -1 -1 62
after_flush look 0 0 0 10 11 5 9 10 32 64
restart dispatch 1 12 0 9 0 0 0 38 39 64
random_mix random 300 0 0 0 0 0 0 -1 -1 -1
final_look look 0 0 0 1 2 3 4 -1 -1 -1
